//--- project.f
source/rx_seq_pkg.sv
source/rx_clk_pkg.sv
source/rx_seq_inputs.sv
source/rx_pll_model.sv
source/rx_reset_seq.sv
source/rx_reset_sync.sv
source/rx_clocks.sv
verif/rx_clocks_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the rx_clocks testbench with verilator, output goes to sim.log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
   --top-module rx_clocks_tb -f project.f -o rx_clocks_sim > sim.log 2>&1 \
   && ./obj_dir/rx_clocks_sim >> sim.log 2>&1 \
   || { echo "build or simulation error, see sim.log"; exit 1; }

grep -q "SOME TESTS FAILED" sim.log \
   && { echo "simulation failed, see sim.log"; exit 1; } \
   || echo "simulation passed"

//--- verif/rx_clocks_tb.sv
`timescale 1ns/1ps

module rx_clocks_tb;

   // testbench copies of the dut parameters
   localparam int RCW         = 4;
   localparam int LOCK_CYCLES = 20;
   localparam int CAL_CYCLES  = 12;
   localparam int STAGES      = 2;

   localparam int SYS_PERIOD   = 20;   // ns
   localparam int RX_PERIOD    = 10;   // ns
   localparam int RESET_CYCLES = 4;
   localparam int NUM_ROWS     = 5;

   // bounds in sys_clk cycles
   localparam int HB_PERIOD      = 1 << RCW;
   localparam int LOCK_SYS       = (LOCK_CYCLES * RX_PERIOD + SYS_PERIOD - 1) / SYS_PERIOD;
   localparam int START_BOUND    = 3 * HB_PERIOD + LOCK_SYS + STAGES;
   localparam int SOFT_BOUND     = HB_PERIOD + 1;
   localparam int HOLD_CYCLES    = HB_PERIOD;   // stopped clock window
   localparam int RELEASE_CYCLES = (STAGES + 2) * 4 * RX_PERIOD / SYS_PERIOD;

   // one stimulus row
   typedef struct packed
   {
      logic tx_active;
      logic soft_reset;
      int   bound;        // sys_clk cycles to reach exp_active
      logic exp_active;
   } row_t;

   logic sys_clk    = 1'b0;
   logic rx_clkin   = 1'b0;
   logic rx_reset   = 1'b1;
   logic soft_reset = 1'b0;
   logic tx_active  = 1'b0;
   logic rx_lclk;
   logic rx_lclk_div4;
   logic rx_active;
   logic erx_reset;
   logic erx_io_reset;

   row_t  rows      [NUM_ROWS];
   string row_names [NUM_ROWS];
   logic  table_ready = 1'b0;

   int  seed        = 32'h64b6_4c53;
   int  sys_offset  = 0;
   real rx_offset   = 0.0;
   bit  sys_started = 1'b0;
   bit  rx_started  = 1'b0;

   int  check_count   = 0;
   int  error_count   = 0;
   int  fast_edges    = 0;     // rx_lclk edges since last div4 edge
   bit  ratio_armed   = 1'b0;
   real last_fast     = 0.0;
   int  io_edges      = 0;     // rx_lclk edges while active
   int  core_edges    = 0;     // rx_lclk_div4 edges while active
   int  io_releases   = 0;
   int  core_releases = 0;
   int  lclk_toggles  = 0;
   int  div4_toggles  = 0;

   rx_clocks #(
      .RCW         (RCW),
      .LOCK_CYCLES (LOCK_CYCLES),
      .CAL_CYCLES  (CAL_CYCLES),
      .STAGES      (STAGES)
   ) rx_clocks_inst (
      .sys_clk      (sys_clk),
      .rx_clkin     (rx_clkin),
      .rx_reset     (rx_reset),
      .soft_reset   (soft_reset),
      .tx_active    (tx_active),
      .rx_lclk      (rx_lclk),
      .rx_lclk_div4 (rx_lclk_div4),
      .rx_active    (rx_active),
      .erx_reset    (erx_reset),
      .erx_io_reset (erx_io_reset)
   );

   // ##########################################################
   // clocks
   // ##########################################################

   always
   begin
      if (!sys_started)
      begin
         sys_started = 1'b1;
         sys_offset  = $unsigned($random(seed)) % 10;   // whole ns
         #(sys_offset);
      end
      #(SYS_PERIOD / 2) sys_clk = ~sys_clk;
   end

   // half ns offset, so rx edges never meet sys_clk edges
   always
   begin
      if (!rx_started)
      begin
         rx_started = 1'b1;
         rx_offset  = real'($unsigned($random(seed)) % 5) + 0.5;
         #(rx_offset);
      end
      #(RX_PERIOD / 2) rx_clkin = ~rx_clkin;
   end

   // ##########################################################
   // clock and reset monitors
   // ##########################################################

   always @(posedge rx_lclk)
   begin
      if ($realtime - last_fast > 1.5 * RX_PERIOD)
         ratio_armed = 1'b0;   // clock just restarted
      last_fast  = $realtime;
      fast_edges = fast_edges + 1;
      if (rx_active)
         io_edges = io_edges + 1;
      else
         io_edges = 0;
   end

   always @(posedge rx_lclk_div4)
   begin
      if (ratio_armed)
         check_value("clock ratio", 4, fast_edges);
      ratio_armed = 1'b1;
      fast_edges  = 0;
      if (rx_active)
         core_edges = core_edges + 1;
      else
         core_edges = 0;
   end

   always @(negedge erx_io_reset)
   begin
      check_value("erx_io_reset release edge", STAGES, io_edges);
      io_releases = io_releases + 1;
   end

   always @(negedge erx_reset)
   begin
      check_value("erx_reset release edge", STAGES, core_edges);
      core_releases = core_releases + 1;
   end

   always @(rx_lclk)
      lclk_toggles = lclk_toggles + 1;

   always @(rx_lclk_div4)
      div4_toggles = div4_toggles + 1;

   // ##########################################################
   // tasks
   // ##########################################################

   task automatic check_value(input string test_name, input int expected, input int actual);
      check_count = check_count + 1;
      if (expected != actual)
      begin
         error_count = error_count + 1;
         $display("ERR %s expected %0d actual %0d", test_name, expected, actual);
      end
   endtask

   task automatic fill_table();
      row_names[0] = "startup";
      rows[0]      = '{tx_active: 1'b1, soft_reset: 1'b0, bound: START_BOUND, exp_active: 1'b1};
      row_names[1] = "soft disable";
      rows[1]      = '{tx_active: 1'b1, soft_reset: 1'b1, bound: SOFT_BOUND, exp_active: 1'b0};
      row_names[2] = "soft enable";
      rows[2]      = '{tx_active: 1'b1, soft_reset: 1'b0, bound: START_BOUND, exp_active: 1'b1};
      row_names[3] = "async drop";
      rows[3]      = '{tx_active: 1'b0, soft_reset: 1'b0, bound: 0, exp_active: 1'b0};
      row_names[4] = "restart";
      rows[4]      = '{tx_active: 1'b1, soft_reset: 1'b0, bound: START_BOUND, exp_active: 1'b1};
      table_ready  = 1'b1;
   endtask

   task automatic apply_row(input int idx);
      row_t r;
      int   waited;
      int   lclk_before;
      int   div4_before;
      r = rows[idx];
      @(negedge sys_clk);   // mid cycle
      tx_active  = r.tx_active;
      soft_reset = r.soft_reset;
      #1;
      waited = 0;
      while (rx_active !== r.exp_active && waited < r.bound)
      begin
         if (r.exp_active)
            check_value({row_names[idx], " erx_reset held"}, 1, int'(erx_reset));
         @(posedge sys_clk);
         #1;
         waited = waited + 1;
      end
      check_value(row_names[idx], int'(r.exp_active), int'(rx_active));
      if (r.exp_active)
      begin
         // domain resets release a few slow clock edges later
         waited = 0;
         while ((erx_reset || erx_io_reset) && waited < RELEASE_CYCLES)
         begin
            @(posedge sys_clk);
            #1;
            waited = waited + 1;
         end
         check_value({row_names[idx], " erx_io_reset"}, 0, int'(erx_io_reset));
         check_value({row_names[idx], " erx_reset"}, 0, int'(erx_reset));
      end
      else
      begin
         check_value({row_names[idx], " erx_io_reset"}, 1, int'(erx_io_reset));
         check_value({row_names[idx], " erx_reset"}, 1, int'(erx_reset));
         // pll held in reset, both clocks parked low
         lclk_before = lclk_toggles;
         div4_before = div4_toggles;
         repeat (HOLD_CYCLES) @(posedge sys_clk);
         #1;
         check_value({row_names[idx], " rx_lclk toggles"}, lclk_before, lclk_toggles);
         check_value({row_names[idx], " div4 toggles"}, div4_before, div4_toggles);
         check_value({row_names[idx], " rx_lclk level"}, 0, int'(rx_lclk));
         check_value({row_names[idx], " div4 level"}, 0, int'(rx_lclk_div4));
      end
   endtask

   // ##########################################################
   // main sequence and watchdog
   // ##########################################################

   initial
   begin
      int rises;
      rises      = 0;
      rx_reset   = 1'b1;
      tx_active  = 1'b0;
      soft_reset = 1'b0;
      fill_table();
      repeat (RESET_CYCLES) @(posedge sys_clk);
      @(negedge sys_clk);
      rx_reset = 1'b0;   // tx_active still holds the sequencer
      for (int i = 0; i < NUM_ROWS; i++)
      begin
         apply_row(i);
         if (rows[i].exp_active)
            rises = rises + 1;
      end
      repeat (2) @(posedge sys_clk);
      check_value("erx_io_reset releases", rises, io_releases);
      check_value("erx_reset releases", rises, core_releases);
      $display("checks: %0d  errors: %0d", check_count, error_count);
      if (error_count == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

   initial
   begin
      int limit;
      limit = RESET_CYCLES + 50;   // margin for offsets and wrap-up
      wait (table_ready);
      for (int i = 0; i < NUM_ROWS; i++)
         limit = limit + rows[i].bound + HOLD_CYCLES + RELEASE_CYCLES + 2;
      #(limit * SYS_PERIOD);
      $display("timeout: run did not finish within %0d sys_clk cycles", limit);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule : rx_clocks_tb

//--- source/rx_clocks.sv
`timescale 1ns/1ps

module rx_clocks
#(
   parameter int RCW         = 4,    // heartbeat counter width
   parameter int LOCK_CYCLES = 20,   // rx_clkin edges to pll lock
   parameter int CAL_CYCLES  = 12,   // rx_clkin edges to cal ready
   parameter int STAGES      = 2     // synchronizer depth
)
(
   input  logic sys_clk,        // always on
   input  logic rx_clkin,       // receive input clock
   input  logic rx_reset,       // power-on reset
   input  logic soft_reset,     // high disables the receiver
   input  logic tx_active,      // far end transmitter up
   output logic rx_lclk,        // fast receive clock
   output logic rx_lclk_div4,   // slow logic clock
   output logic rx_active,
   output logic erx_reset,      // core reset, rx_lclk_div4 domain
   output logic erx_io_reset    // io reset, rx_lclk domain
);

   logic                    seq_reset;
   logic                    heartbeat;
   rx_clk_pkg::clk_status_t clk_raw;
   rx_clk_pkg::clk_status_t clk_sync;
   rx_seq_pkg::seq_status_t seq_status;

   // sequencer held while the link partner is down
   assign seq_reset = rx_reset | ~tx_active;

   // ##########################################################
   // clock generation
   // ##########################################################

   rx_pll_model #(
      .LOCK_CYCLES (LOCK_CYCLES),
      .CAL_CYCLES  (CAL_CYCLES)
   ) pll_model_inst (
      .rx_clkin     (rx_clkin),
      .pll_reset    (seq_status.pll_reset),
      .rx_lclk      (rx_lclk),
      .rx_lclk_div4 (rx_lclk_div4),
      .clk_raw      (clk_raw)
   );

   // ##########################################################
   // reset sequencing
   // ##########################################################

   rx_seq_inputs #(
      .RCW    (RCW),
      .STAGES (STAGES)
   ) seq_inputs_inst (
      .sys_clk   (sys_clk),
      .seq_reset (seq_reset),
      .clk_raw   (clk_raw),
      .clk_sync  (clk_sync),
      .heartbeat (heartbeat)
   );

   rx_reset_seq reset_seq_inst (
      .sys_clk    (sys_clk),
      .seq_reset  (seq_reset),
      .heartbeat  (heartbeat),
      .soft_reset (soft_reset),
      .clk_sync   (clk_sync),
      .status     (seq_status)
   );

   assign rx_active = seq_status.active;

   // ##########################################################
   // domain resets
   // ##########################################################

   rx_reset_sync #(
      .STAGES (STAGES)
   ) io_reset_sync_inst (
      .clk       (rx_lclk),
      .reset_in  (seq_status.core_reset),
      .reset_out (erx_io_reset)
   );

   rx_reset_sync #(
      .STAGES (STAGES)
   ) core_reset_sync_inst (
      .clk       (rx_lclk_div4),
      .reset_in  (seq_status.core_reset),
      .reset_out (erx_reset)
   );

endmodule : rx_clocks

//--- source/rx_reset_sync.sv
`timescale 1ns/1ps

// async assert, sync release, one per receive clock domain
module rx_reset_sync
#(
   parameter int STAGES = 2   // release delay in clk edges
)
(
   input  logic clk,         // domain clock
   input  logic reset_in,    // async reset, active high
   output logic reset_out    // domain reset, active high
);

   logic [STAGES-1:0] fill_pipe;   // ones shift in after release

   always_ff @(posedge clk or posedge reset_in)
   begin
      if (reset_in)
      begin
         fill_pipe <= '0;
      end
      else
      begin
         fill_pipe <= {fill_pipe[STAGES-2:0], 1'b1};
      end
   end

   // out of reset once the first one reaches the end
   assign reset_out = ~fill_pipe[STAGES-1];

endmodule : rx_reset_sync

//--- source/rx_reset_seq.sv
`timescale 1ns/1ps

module rx_reset_seq
(
   input  logic                    sys_clk,
   input  logic                    seq_reset,    // por or tx inactive
   input  logic                    heartbeat,    // state step enable
   input  logic                    soft_reset,   // sw disable, level
   input  rx_clk_pkg::clk_status_t clk_sync,     // synced lock flags
   output rx_seq_pkg::seq_status_t status
);

   rx_seq_pkg::seq_state_t state;
   rx_seq_pkg::seq_state_t next_state;

   // ##########################################################
   // state register
   // ##########################################################

   always_ff @(posedge sys_clk or posedge seq_reset)
   begin
      if (seq_reset)
      begin
         state <= rx_seq_pkg::reset_all;   // drops active at once
      end
      else
      begin
         state <= next_state;
      end
   end

   // moves only on a heartbeat cycle
   always_comb
   begin
      next_state = state;
      if (heartbeat)
      begin
         case (state)
            rx_seq_pkg::reset_all:
            begin
               if (!soft_reset)
                  next_state = rx_seq_pkg::start_pll;   // enabled, release pll
            end
            rx_seq_pkg::start_pll:
            begin
               if (clk_sync.locked && clk_sync.cal_ready)
                  next_state = rx_seq_pkg::active;      // clocks good
            end
            rx_seq_pkg::active:
            begin
               if (soft_reset)
                  next_state = rx_seq_pkg::reset_all;   // back to full reset
            end
            default:
               next_state = rx_seq_pkg::reset_all;      // unused code
         endcase
      end
   end

   // ##########################################################
   // status decode
   // ##########################################################

   assign status.pll_reset  = (state == rx_seq_pkg::reset_all);
   assign status.core_reset = (state != rx_seq_pkg::active);
   assign status.active     = (state == rx_seq_pkg::active);

endmodule : rx_reset_seq

//--- source/rx_pll_model.sv
`timescale 1ns/1ps

// stand-in for the receive pll, clock buffers and delay controller
module rx_pll_model
#(
   parameter int LOCK_CYCLES = 20,   // rx_clkin edges to lock
   parameter int CAL_CYCLES  = 12    // rx_clkin edges to cal ready
)
(
   input  logic                    rx_clkin,
   input  logic                    pll_reset,
   output logic                    rx_lclk,        // fast clock at rx_clkin rate
   output logic                    rx_lclk_div4,   // slow logic clock
   output rx_clk_pkg::clk_status_t clk_raw         // lock flags in rx_clkin domain
);

   // counter only needs to reach the later of the two events
   localparam int MAX_CYCLES = (LOCK_CYCLES > CAL_CYCLES) ? LOCK_CYCLES : CAL_CYCLES;
   localparam int CW         = $clog2(MAX_CYCLES + 1);

   logic [1:0]    div_count;    // divide by four
   logic [CW-1:0] edge_count;   // edges since pll_reset release

   // ##########################################################
   // clock outputs
   // ##########################################################

   // input clock gated low in reset
   assign rx_lclk = rx_clkin & ~pll_reset;

   always_ff @(posedge rx_clkin or posedge pll_reset)
   begin
      if (pll_reset)
      begin
         div_count <= 2'b00;
      end
      else
      begin
         div_count <= div_count + 2'b01;
      end
   end

   // msb toggles each time the low bit wraps
   assign rx_lclk_div4 = div_count[1];

   // ##########################################################
   // lock and calibration
   // ##########################################################

   always_ff @(posedge rx_clkin or posedge pll_reset)
   begin
      if (pll_reset)
      begin
         edge_count <= '0;
      end
      else if (edge_count != CW'(MAX_CYCLES))
      begin
         edge_count <= edge_count + 1'b1;   // saturates so flags stay set
      end
   end

   // both drop at once when pll_reset returns
   assign clk_raw.locked    = (edge_count >= CW'(LOCK_CYCLES));
   assign clk_raw.cal_ready = (edge_count >= CW'(CAL_CYCLES));

endmodule : rx_pll_model

//--- source/rx_seq_inputs.sv
`timescale 1ns/1ps

module rx_seq_inputs
#(
   parameter int RCW    = 4,   // heartbeat counter width
   parameter int STAGES = 2    // synchronizer depth
)
(
   input  logic                    sys_clk,
   input  logic                    seq_reset,
   input  rx_clk_pkg::clk_status_t clk_raw,    // raw flags from pll model
   output rx_clk_pkg::clk_status_t clk_sync,   // sys_clk domain copy
   output logic                    heartbeat   // one cycle every 2**RCW cycles
);

   // ##########################################################
   // heartbeat
   // ##########################################################

   // free running heartbeat counter
   logic [RCW-1:0] hb_count = '0;
   logic           hb_pulse = 1'b0;

   always_ff @(posedge sys_clk)
   begin
      hb_count <= hb_count + 1'b1;   // wraps through zero
      hb_pulse <= ~(|hb_count);      // one cycle per wrap
   end

   assign heartbeat = hb_pulse;

   // ##########################################################
   // lock flag synchronizer
   // ##########################################################

   // stage 0 samples the raw flags
   rx_clk_pkg::clk_status_t [STAGES-1:0] sync_pipe;

   always_ff @(posedge sys_clk or posedge seq_reset)
   begin
      if (seq_reset)
      begin
         sync_pipe <= '0;   // flags read as not ready
      end
      else
      begin
         sync_pipe <= {sync_pipe[STAGES-2:0], clk_raw};
      end
   end

   assign clk_sync = sync_pipe[STAGES-1];   // last stage to sequencer

endmodule : rx_seq_inputs

//--- source/rx_clk_pkg.sv
// ##########################################################
// clock generator status
// ##########################################################

package rx_clk_pkg;

   // raw in rx_clkin domain, synced copy in sys_clk domain
   typedef struct packed
   {
      logic locked;        // pll lock
      logic cal_ready;     // delay line calibration done
   } clk_status_t;

endpackage : rx_clk_pkg

//--- source/rx_seq_pkg.sv
// ##########################################################
// reset sequencer types
// ##########################################################

package rx_seq_pkg;

   // sequencer states, advanced only on heartbeat
   typedef enum logic [1:0]
   {
      reset_all = 2'b00,   // pll and core held in reset
      start_pll = 2'b01,   // pll running, waiting for lock
      active    = 2'b10    // receiver up
   } seq_state_t;

   // decoded sequencer outputs
   // all three are plain levels straight from the state register
   typedef struct packed
   {
      logic pll_reset;     // high in reset_all only
      logic core_reset;    // high until active
      logic active;        // receiver active indicator
   } seq_status_t;

endpackage : rx_seq_pkg
